// ==== verilog/rv32e_pkg.sv ====
package rv32e_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [16:0] alu_op_t;
    typedef logic [6:0]  opcode_t;

    // One-hot ALU select positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 6;
    localparam int ALU_SLL  = 7;
    localparam int ALU_SRL  = 8;
    localparam int ALU_SRA  = 9;
    localparam int ALU_LUI  = 10;
    localparam int ALU_BNE  = 11;
    localparam int ALU_BEQ  = 12;
    localparam int ALU_BGE  = 13;
    localparam int ALU_BGEU = 14;
    localparam int ALU_BLT  = 15;
    localparam int ALU_BLTU = 16;

    localparam xlen_t RESET_PC = 32'h0000_0000;

    localparam opcode_t OP_REG    = 7'h33;
    localparam opcode_t OP_IMM    = 7'h13;
    localparam opcode_t OP_LUI    = 7'h37;
    localparam opcode_t OP_AUIPC  = 7'h17;
    localparam opcode_t OP_JAL    = 7'h6f;
    localparam opcode_t OP_JALR   = 7'h67;
    localparam opcode_t OP_BRANCH = 7'h63;
    localparam opcode_t OP_STORE  = 7'h23; // Immediate only, never executed
    localparam opcode_t OP_SYSTEM = 7'h73;

    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t    pc;
        xlen_t    imm;
        xlen_t    src1;
        xlen_t    src2;
        reg_idx_t rd;
        alu_op_t  alu_op;
        logic     gpr_we;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     is_jal;
        logic     is_jalr;
        logic     is_branch;
        logic     is_ebreak;
        logic     is_illegal;
    } decode_pkt_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    data;
        logic     gpr_we;
    } commit_t;

    typedef enum logic {
        fetch_run,
        fetch_halt
    } fetch_state_t;

endpackage

// ==== verilog/rv32e_fetch.sv ====
`timescale 1ns/1ps

module rv32e_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  rv32e_pkg::xlen_t      imem_data,
    input  logic                  redirect_valid,
    input  rv32e_pkg::xlen_t      redirect_pc,
    input  logic                  halt_req,
    output rv32e_pkg::xlen_t      imem_addr,
    output rv32e_pkg::fetch_pkt_t fetch_pkt,
    output logic                  fetch_valid,
    output logic                  halted
);

    rv32e_pkg::xlen_t        pc;
    rv32e_pkg::fetch_state_t state;
    logic                    advance;

    assign imem_addr = pc;
    assign halted    = (state == rv32e_pkg::fetch_halt);

    // Normal sequential fetch, no redirect or halt this cycle
    assign advance = (state == rv32e_pkg::fetch_run) && !halt_req && !redirect_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= rv32e_pkg::fetch_run;
            pc          <= rv32e_pkg::RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            case (state)
                rv32e_pkg::fetch_run: begin
                    if (halt_req) begin
                        state       <= rv32e_pkg::fetch_halt;
                        fetch_valid <= 1'b0;
                    end else if (redirect_valid) begin
                        pc          <= redirect_pc; // Wrong-path word is dropped
                        fetch_valid <= 1'b0;
                    end else begin
                        pc          <= pc + 32'd4;
                        fetch_valid <= 1'b1;
                    end
                end
                default: fetch_valid <= 1'b0; // Parked until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            fetch_pkt <= '{pc: pc, inst: imem_data};
        end
    end

endmodule

// ==== verilog/rv32e_gpr.sv ====
`timescale 1ns/1ps

module rv32e_gpr (
    input  logic                clk,
    input  logic                rst,
    input  rv32e_pkg::reg_idx_t rs1,
    input  rv32e_pkg::reg_idx_t rs2,
    input  logic                gpr_we,
    input  rv32e_pkg::reg_idx_t gpr_waddr,
    input  rv32e_pkg::xlen_t    gpr_wdata,
    output rv32e_pkg::xlen_t    src1,
    output rv32e_pkg::xlen_t    src2
);

    rv32e_pkg::xlen_t regs [16];
    logic             wr_en;
    logic             byp1;
    logic             byp2;

    assign wr_en = gpr_we && (gpr_waddr != 4'd0); // x0 stays zero

    // Write-first forwarding of the result being retired this cycle
    assign byp1 = wr_en && (gpr_waddr == rs1);
    assign byp2 = wr_en && (gpr_waddr == rs2);

    assign src1 = byp1 ? gpr_wdata : regs[rs1];
    assign src2 = byp2 ? gpr_wdata : regs[rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[gpr_waddr] <= gpr_wdata;
        end
    end

endmodule

// ==== verilog/rv32e_decode.sv ====
`timescale 1ns/1ps

module rv32e_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  rv32e_pkg::fetch_pkt_t  fetch_pkt,
    input  logic                   fetch_valid,
    input  rv32e_pkg::xlen_t       src1,
    input  rv32e_pkg::xlen_t       src2,
    input  logic                   redirect_valid,
    output rv32e_pkg::reg_idx_t    rs1,
    output rv32e_pkg::reg_idx_t    rs2,
    output rv32e_pkg::decode_pkt_t decode_pkt,
    output logic                   decode_valid
);

    rv32e_pkg::xlen_t      inst;
    rv32e_pkg::opcode_t    opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rv32e_pkg::xlen_t      imm_i;
    rv32e_pkg::xlen_t      imm_s;
    rv32e_pkg::xlen_t      imm_b;
    rv32e_pkg::xlen_t      imm_u;
    rv32e_pkg::xlen_t      imm_j;
    logic                  op_reg;
    logic                  op_imm;
    logic                  f7_zero;
    logic                  f7_alt;
    logic                  inst_lui;
    logic                  inst_auipc;
    logic                  inst_jal;
    logic                  inst_jalr;
    logic                  inst_ebreak;
    logic                  type_r;
    logic                  type_i;
    logic                  type_b;
    logic                  type_u;
    logic                  bad_reg;
    rv32e_pkg::alu_op_t    alu_op;
    rv32e_pkg::decode_pkt_t pkt_d;

    assign inst   = fetch_pkt.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // RV32E has 16 registers, top index bit is checked below
    assign rs1 = inst[18:15];
    assign rs2 = inst[23:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign op_reg  = (opcode == rv32e_pkg::OP_REG);
    assign op_imm  = (opcode == rv32e_pkg::OP_IMM);
    assign f7_zero = (funct7 == 7'h00);
    assign f7_alt  = (funct7 == 7'h20);

    assign inst_lui    = (opcode == rv32e_pkg::OP_LUI);
    assign inst_auipc  = (opcode == rv32e_pkg::OP_AUIPC);
    assign inst_jal    = (opcode == rv32e_pkg::OP_JAL);
    assign inst_jalr   = (opcode == rv32e_pkg::OP_JALR) && (funct3 == 3'h0);
    assign inst_ebreak = (inst == {12'h001, 13'h0, rv32e_pkg::OP_SYSTEM});

    // Decode table, one-hot per supported instruction
    always_comb begin
        alu_op = '0;
        alu_op[rv32e_pkg::ALU_ADD]  = (op_reg && funct3 == 3'h0 && f7_zero)
                                    || (op_imm && funct3 == 3'h0)
                                    || inst_auipc || inst_jal || inst_jalr;
        alu_op[rv32e_pkg::ALU_SUB]  = op_reg && funct3 == 3'h0 && f7_alt;
        alu_op[rv32e_pkg::ALU_SLT]  = (op_reg && funct3 == 3'h2 && f7_zero)
                                    || (op_imm && funct3 == 3'h2);
        alu_op[rv32e_pkg::ALU_SLTU] = (op_reg && funct3 == 3'h3 && f7_zero)
                                    || (op_imm && funct3 == 3'h3);
        alu_op[rv32e_pkg::ALU_XOR]  = (op_reg || op_imm) && funct3 == 3'h4
                                    && (op_imm || f7_zero);
        alu_op[rv32e_pkg::ALU_OR]   = (op_reg || op_imm) && funct3 == 3'h6
                                    && (op_imm || f7_zero);
        alu_op[rv32e_pkg::ALU_AND]  = (op_reg || op_imm) && funct3 == 3'h7
                                    && (op_imm || f7_zero);
        alu_op[rv32e_pkg::ALU_SLL]  = (op_reg || op_imm) && funct3 == 3'h1 && f7_zero;
        alu_op[rv32e_pkg::ALU_SRL]  = (op_reg || op_imm) && funct3 == 3'h5 && f7_zero;
        alu_op[rv32e_pkg::ALU_SRA]  = (op_reg || op_imm) && funct3 == 3'h5 && f7_alt;
        alu_op[rv32e_pkg::ALU_LUI]  = inst_lui;
        alu_op[rv32e_pkg::ALU_BEQ]  = (opcode == rv32e_pkg::OP_BRANCH) && funct3 == 3'h0;
        alu_op[rv32e_pkg::ALU_BNE]  = (opcode == rv32e_pkg::OP_BRANCH) && funct3 == 3'h1;
        alu_op[rv32e_pkg::ALU_BLT]  = (opcode == rv32e_pkg::OP_BRANCH) && funct3 == 3'h4;
        alu_op[rv32e_pkg::ALU_BGE]  = (opcode == rv32e_pkg::OP_BRANCH) && funct3 == 3'h5;
        alu_op[rv32e_pkg::ALU_BLTU] = (opcode == rv32e_pkg::OP_BRANCH) && funct3 == 3'h6;
        alu_op[rv32e_pkg::ALU_BGEU] = (opcode == rv32e_pkg::OP_BRANCH) && funct3 == 3'h7;
    end

    assign type_r = op_reg && (|alu_op[rv32e_pkg::ALU_SRA:rv32e_pkg::ALU_ADD]);
    assign type_i = (op_imm && (|alu_op[rv32e_pkg::ALU_SRA:rv32e_pkg::ALU_ADD])) || inst_jalr;
    assign type_b = |alu_op[rv32e_pkg::ALU_BLTU:rv32e_pkg::ALU_BNE];
    assign type_u = inst_lui || inst_auipc;

    // x16..x31 do not exist in RV32E
    assign bad_reg = ((type_r || type_i || type_u || inst_jal) && inst[11])
                   || ((type_r || type_i || type_b) && inst[19])
                   || ((type_r || type_b) && inst[24]);

    always_comb begin
        pkt_d             = '0;
        pkt_d.pc          = fetch_pkt.pc;
        pkt_d.src1        = src1;
        pkt_d.src2        = src2;
        pkt_d.rd          = inst[10:7];
        pkt_d.alu_op      = alu_op;
        pkt_d.imm         = ({32{type_i}} & imm_i)
                          | ({32{opcode == rv32e_pkg::OP_STORE}} & imm_s)
                          | ({32{type_b}} & imm_b)
                          | ({32{type_u}} & imm_u)
                          | ({32{inst_jal}} & imm_j);
        pkt_d.gpr_we      = type_r || type_i || type_u || inst_jal;
        pkt_d.src1_is_pc  = inst_jal || inst_auipc || type_b;
        pkt_d.src2_is_imm = type_i || type_u || inst_jal || type_b;
        pkt_d.is_jal      = inst_jal;
        pkt_d.is_jalr     = inst_jalr;
        pkt_d.is_branch   = type_b;
        pkt_d.is_ebreak   = inst_ebreak;
        pkt_d.is_illegal  = !(type_r || type_i || type_b || type_u || inst_jal || inst_ebreak)
                          || bad_reg;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decode_valid <= 1'b0;
        end else begin
            decode_valid <= fetch_valid && !redirect_valid; // Squash behind a taken jump
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            decode_pkt <= pkt_d;
        end
    end

endmodule

// ==== verilog/rv32e_execute.sv ====
`timescale 1ns/1ps

module rv32e_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  rv32e_pkg::decode_pkt_t decode_pkt,
    input  logic                   decode_valid,
    output logic                   gpr_we,
    output rv32e_pkg::reg_idx_t    gpr_waddr,
    output rv32e_pkg::xlen_t       gpr_wdata,
    output logic                   redirect_valid,
    output rv32e_pkg::xlen_t       redirect_pc,
    output logic                   halt_req,
    output logic                   commit_valid,
    output rv32e_pkg::commit_t     commit,
    output logic                   illegal
);

    rv32e_pkg::alu_op_t op;
    rv32e_pkg::xlen_t   op_a;
    rv32e_pkg::xlen_t   op_b;
    rv32e_pkg::xlen_t   sum;
    rv32e_pkg::xlen_t   alu_res;
    rv32e_pkg::xlen_t   sra_res;
    logic [4:0]         shamt;
    logic               exec_valid;
    logic               stop;
    logic               done;
    logic               eq;
    logic               lt;
    logic               ltu;
    logic               taken;

    assign op         = decode_pkt.alu_op;
    assign exec_valid = decode_valid && !done; // Nothing retires past a halt
    assign stop       = decode_pkt.is_ebreak || decode_pkt.is_illegal;

    assign op_a  = decode_pkt.src1_is_pc ? decode_pkt.pc : decode_pkt.src1;
    assign op_b  = decode_pkt.src2_is_imm ? decode_pkt.imm : decode_pkt.src2;
    assign sum   = op_a + op_b;
    assign shamt = op_b[4:0];

    assign sra_res = $signed(op_a) >>> shamt;

    assign alu_res = ({32{op[rv32e_pkg::ALU_ADD]}}  & sum)
                   | ({32{op[rv32e_pkg::ALU_SUB]}}  & (op_a - op_b))
                   | ({32{op[rv32e_pkg::ALU_SLT]}}  & {31'b0, $signed(op_a) < $signed(op_b)})
                   | ({32{op[rv32e_pkg::ALU_SLTU]}} & {31'b0, op_a < op_b})
                   | ({32{op[rv32e_pkg::ALU_AND]}}  & (op_a & op_b))
                   | ({32{op[rv32e_pkg::ALU_OR]}}   & (op_a | op_b))
                   | ({32{op[rv32e_pkg::ALU_XOR]}}  & (op_a ^ op_b))
                   | ({32{op[rv32e_pkg::ALU_SLL]}}  & (op_a << shamt))
                   | ({32{op[rv32e_pkg::ALU_SRL]}}  & (op_a >> shamt))
                   | ({32{op[rv32e_pkg::ALU_SRA]}}  & sra_res)
                   | ({32{op[rv32e_pkg::ALU_LUI]}}  & op_b);

    // Branch compare always uses the register operands
    assign eq  = (decode_pkt.src1 == decode_pkt.src2);
    assign lt  = ($signed(decode_pkt.src1) < $signed(decode_pkt.src2));
    assign ltu = (decode_pkt.src1 < decode_pkt.src2);

    assign taken = decode_pkt.is_branch
                 && ((op[rv32e_pkg::ALU_BNE]  && !eq)
                  || (op[rv32e_pkg::ALU_BEQ]  && eq)
                  || (op[rv32e_pkg::ALU_BGE]  && !lt)
                  || (op[rv32e_pkg::ALU_BGEU] && !ltu)
                  || (op[rv32e_pkg::ALU_BLT]  && lt)
                  || (op[rv32e_pkg::ALU_BLTU] && ltu));

    assign redirect_valid = exec_valid && !stop
                         && (taken || decode_pkt.is_jal || decode_pkt.is_jalr);
    assign redirect_pc    = {sum[31:1], sum[0] && !decode_pkt.is_jalr};

    assign gpr_we    = exec_valid && !stop && decode_pkt.gpr_we;
    assign gpr_waddr = decode_pkt.rd;
    assign gpr_wdata = (decode_pkt.is_jal || decode_pkt.is_jalr) ? decode_pkt.pc + 32'd4
                                                                 : alu_res; // Link or result
    assign halt_req  = exec_valid && stop; // Fires once because done blocks the rest

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done         <= 1'b0;
            illegal      <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            done         <= done || halt_req;
            illegal      <= illegal || (exec_valid && decode_pkt.is_illegal);
            commit_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) begin
            commit <= '{pc: decode_pkt.pc, rd: gpr_waddr, data: gpr_wdata, gpr_we: gpr_we};
        end
    end

endmodule

// ==== verilog/rv32e_core.sv ====
`timescale 1ns/1ps

module rv32e_core (
    input  logic                clk,
    input  logic                rst,
    input  rv32e_pkg::xlen_t    imem_data,
    output rv32e_pkg::xlen_t    imem_addr,
    output logic                commit_valid,
    output rv32e_pkg::commit_t  commit,
    output logic                halted,
    output logic                illegal
);

    rv32e_pkg::fetch_pkt_t  fetch_pkt;
    logic                   fetch_valid;
    rv32e_pkg::reg_idx_t    rs1;
    rv32e_pkg::reg_idx_t    rs2;
    rv32e_pkg::xlen_t       src1;
    rv32e_pkg::xlen_t       src2;
    rv32e_pkg::decode_pkt_t decode_pkt;
    logic                   decode_valid;
    logic                   gpr_we;
    rv32e_pkg::reg_idx_t    gpr_waddr;
    rv32e_pkg::xlen_t       gpr_wdata;
    logic                   redirect_valid;
    rv32e_pkg::xlen_t       redirect_pc;
    logic                   halt_req;

    rv32e_fetch u_fetch (
        .clk            (clk),
        .rst            (rst),
        .imem_data      (imem_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halt_req       (halt_req),
        .imem_addr      (imem_addr),
        .fetch_pkt      (fetch_pkt),
        .fetch_valid    (fetch_valid),
        .halted         (halted)
    );

    rv32e_gpr u_gpr (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .gpr_we    (gpr_we),
        .gpr_waddr (gpr_waddr),
        .gpr_wdata (gpr_wdata),
        .src1      (src1),
        .src2      (src2)
    );

    rv32e_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .fetch_pkt      (fetch_pkt),
        .fetch_valid    (fetch_valid),
        .src1           (src1),
        .src2           (src2),
        .redirect_valid (redirect_valid),
        .rs1            (rs1),
        .rs2            (rs2),
        .decode_pkt     (decode_pkt),
        .decode_valid   (decode_valid)
    );

    rv32e_execute u_execute (
        .clk            (clk),
        .rst            (rst),
        .decode_pkt     (decode_pkt),
        .decode_valid   (decode_valid),
        .gpr_we         (gpr_we),
        .gpr_waddr      (gpr_waddr),
        .gpr_wdata      (gpr_wdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halt_req       (halt_req),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .illegal        (illegal)
    );

endmodule

// ==== dv/rv32e_core_tests.svh ====
logic [2:0] imm_ops [6] = '{3'h0, 3'h2, 3'h3, 3'h4, 3'h6, 3'h7};

task automatic test_alu();
    int rd;
    begin_test();
    load_const(1, $random(seed));
    load_const(2, $random(seed));
    for (int f3 = 0; f3 < 8; f3++) begin
        emit(r_type(7'h00, f3[2:0], 3 + f3, 1, 2));
    end
    emit(r_type(7'h20, 3'h0, 11, 1, 2)); // sub
    emit(r_type(7'h20, 3'h5, 12, 1, 2)); // sra
    rd = 13;
    foreach (imm_ops[k]) begin
        emit(i_type($random(seed), imm_ops[k], rd, 1, rv32e_pkg::OP_IMM));
        rd = (rd == 15) ? 3 : rd + 1;
    end
    emit(i_type($random(seed) & 31, 3'h1, 4, 2, rv32e_pkg::OP_IMM));
    emit(i_type($random(seed) & 31, 3'h5, 5, 1, rv32e_pkg::OP_IMM));
    emit(i_type(32'h400 | ($random(seed) & 31), 3'h5, 6, 1, rv32e_pkg::OP_IMM));
    emit(r_type(7'h00, 3'h0, 0, 1, 2)); // Result to x0 is dropped
    emit(r_type(7'h00, 3'h0, 7, 0, 1));
    emit(EBREAK);
    run_program();
    end_test("alu");
endtask

task automatic test_chain();
    begin_test();
    load_const(2, $random(seed));
    emit(i_type($random(seed), 3'h0, 1, 0, rv32e_pkg::OP_IMM));
    for (int k = 0; k < 10; k++) begin
        case (k % 3)
            0:       emit(r_type(7'h00, 3'h0, 1, 1, 2));
            1:       emit(i_type($random(seed), 3'h4, 1, 1, rv32e_pkg::OP_IMM));
            default: emit(r_type(7'h20, 3'h0, 1, 1, 2));
        endcase
    end
    emit(EBREAK);
    run_program();
    end_test("chain");
endtask

task automatic test_branches();
    int f3s  [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    int rs1s [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
    int rs2s [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    begin_test();
    emit(i_type(-3, 3'h0, 1, 0, rv32e_pkg::OP_IMM));
    emit(i_type(5, 3'h0, 2, 0, rv32e_pkg::OP_IMM));
    emit(i_type(5, 3'h0, 3, 0, rv32e_pkg::OP_IMM));
    for (int k = 0; k < 12; k++) begin
        emit(b_type(8, f3s[k][2:0], rs1s[k], rs2s[k])); // Even entries are taken
        emit(i_type(1, 3'h0, 6, 6, rv32e_pkg::OP_IMM));
    end
    emit(EBREAK);
    run_program();
    end_test("branches");
endtask

task automatic test_jumps();
    begin_test();
    emit(j_type(12, 1));
    emit(i_type(1, 3'h0, 7, 7, rv32e_pkg::OP_IMM));
    emit(i_type(1, 3'h0, 7, 7, rv32e_pkg::OP_IMM));
    emit(i_type(29, 3'h0, 2, 0, rv32e_pkg::OP_IMM)); // Odd target address
    emit(i_type(0, 3'h0, 3, 2, rv32e_pkg::OP_JALR));
    emit(i_type(1, 3'h0, 7, 7, rv32e_pkg::OP_IMM));
    emit(i_type(1, 3'h0, 7, 7, rv32e_pkg::OP_IMM));
    emit(u_type(0, 5, rv32e_pkg::OP_AUIPC));
    emit(i_type(12, 3'h0, 0, 5, rv32e_pkg::OP_JALR));
    emit(i_type(1, 3'h0, 7, 7, rv32e_pkg::OP_IMM));
    emit(r_type(7'h00, 3'h0, 6, 1, 3));
    emit(EBREAK);
    run_program();
    end_test("jumps");
endtask

task automatic test_halt();
    begin_test();
    emit(i_type(3, 3'h0, 1, 0, rv32e_pkg::OP_IMM));
    emit(i_type(4, 3'h0, 2, 1, rv32e_pkg::OP_IMM));
    emit(EBREAK);
    emit(i_type(5, 3'h0, 3, 0, rv32e_pkg::OP_IMM)); // Must never retire
    emit(i_type(6, 3'h0, 4, 0, rv32e_pkg::OP_IMM));
    run_program();
    end_test("halt");
endtask

task automatic test_illegal();
    rv32e_pkg::xlen_t bad [4];
    begin_test();
    bad[0] = i_type(0, 3'h2, 2, 1, 7'h03);      // lw
    bad[1] = s_type(4, 3'h2, 1, 2);             // sw
    bad[2] = i_type(32'h300, 3'h1, 3, 1, 7'h73); // csrrw
    bad[3] = 32'h0000_007f;
    for (int k = 0; k < 4; k++) begin
        clear_program();
        emit(i_type(5, 3'h0, 1, 0, rv32e_pkg::OP_IMM));
        emit(bad[k]);
        emit(i_type(1, 3'h0, 2, 0, rv32e_pkg::OP_IMM));
        run_program();
    end
    end_test("illegal");
endtask

// ==== dv/rv32e_core_tb.sv ====
`timescale 1ns/1ps

module rv32e_core_tb;

    localparam int  NUM_TESTS  = 6;
    localparam int  CLK_PERIOD = 4;
    localparam int  RUN_LIMIT  = 300;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic                       clk;
    logic                       rst;
    rv32e_pkg::xlen_t           imem_data;
    rv32e_pkg::xlen_t           imem_addr;
    logic                       commit_valid;
    rv32e_pkg::commit_t         commit;
    logic                       halted;
    logic                       illegal;

    rv32e_pkg::xlen_t           imem [256];
    int                         prog_idx;
    int                         seed;
    int                         errors;
    int                         tests_failed;
    int                         test_start_errors;
    rv32e_pkg::commit_t         exp_q [$];
    int                         gap_q [$];
    logic                       exp_illegal;

    rv32e_core u_rv32e_core (
        .clk          (clk),
        .rst          (rst),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halted       (halted),
        .illegal      (illegal)
    );

    assign imem_data = imem[imem_addr[9:2]]; // Combinational instruction port

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input rv32e_pkg::xlen_t got,
                              input rv32e_pkg::xlen_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input rv32e_pkg::reg_idx_t got,
                             input rv32e_pkg::reg_idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Encoders straight from the RV32I instruction formats
    function automatic rv32e_pkg::xlen_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                                input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv32e_pkg::OP_REG};
    endfunction

    function automatic rv32e_pkg::xlen_t i_type(input int imm, input logic [2:0] f3,
                                                input int rd, input int rs1,
                                                input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic rv32e_pkg::xlen_t s_type(input int imm, input logic [2:0] f3,
                                                input int rs1, input int rs2);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
    endfunction

    function automatic rv32e_pkg::xlen_t b_type(input int imm, input logic [2:0] f3,
                                                input int rs1, input int rs2);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
                rv32e_pkg::OP_BRANCH};
    endfunction

    function automatic rv32e_pkg::xlen_t u_type(input int imm20, input int rd,
                                                input logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic rv32e_pkg::xlen_t j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv32e_pkg::OP_JAL};
    endfunction

    task automatic clear_program();
        rv32e_pkg::xlen_t addr;
        for (int i = 0; i < 256; i++) begin
            addr    = i * 4;
            imem[i] = {addr[24:0], 7'h00}; // Opcode zero, traps if ever reached
        end
        prog_idx = 0;
    endtask

    task automatic emit(input rv32e_pkg::xlen_t inst);
        imem[prog_idx] = inst;
        prog_idx++;
    endtask

    task automatic load_const(input int rd, input rv32e_pkg::xlen_t value);
        rv32e_pkg::xlen_t hi;
        hi = (value + 32'h800) >> 12;
        emit(u_type(int'(hi), rd, rv32e_pkg::OP_LUI));
        emit(i_type(int'(value), 3'h0, rd, rd, rv32e_pkg::OP_IMM));
    endtask

    function automatic rv32e_pkg::xlen_t alu_calc(input logic [2:0] f3, input logic alt,
                                                  input rv32e_pkg::xlen_t a,
                                                  input rv32e_pkg::xlen_t b);
        case (f3)
            3'h0:    return alt ? a - b : a + b;
            3'h1:    return a << b[4:0];
            3'h2:    return {31'b0, $signed(a) < $signed(b)};
            3'h3:    return {31'b0, a < b};
            3'h4:    return a ^ b;
            3'h5:    return alt ? rv32e_pkg::xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'h6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // In-order ISA model, fills the expected commit stream
    task automatic model_run();
        rv32e_pkg::xlen_t   regs [16];
        rv32e_pkg::xlen_t   pc;
        rv32e_pkg::xlen_t   next_pc;
        rv32e_pkg::xlen_t   inst;
        rv32e_pkg::xlen_t   a;
        rv32e_pkg::xlen_t   b;
        rv32e_pkg::xlen_t   imm_i;
        rv32e_pkg::xlen_t   imm_b;
        rv32e_pkg::commit_t c;
        logic [2:0]         f3;
        logic               stop;
        logic               cond;
        int                 gap;
        exp_q.delete();
        gap_q.delete();
        exp_illegal = 1'b0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        pc   = rv32e_pkg::RESET_PC;
        gap  = 1;
        stop = 1'b0;
        for (int step = 0; step < 200 && !stop; step++) begin
            inst    = imem[pc[9:2]];
            f3      = inst[14:12];
            a       = regs[inst[18:15]];
            b       = regs[inst[23:20]];
            imm_i   = {{20{inst[31]}}, inst[31:20]};
            imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            next_pc = pc + 32'd4;
            c       = '{pc: pc, rd: inst[10:7], data: '0, gpr_we: 1'b1};
            case (inst[6:0])
                rv32e_pkg::OP_REG:   c.data = alu_calc(f3, inst[30], a, b);
                rv32e_pkg::OP_IMM:   c.data = alu_calc(f3, f3 == 3'h5 && inst[30], a, imm_i);
                rv32e_pkg::OP_LUI:   c.data = {inst[31:12], 12'b0};
                rv32e_pkg::OP_AUIPC: c.data = pc + {inst[31:12], 12'b0};
                rv32e_pkg::OP_JAL: begin
                    c.data  = pc + 32'd4;
                    next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                rv32e_pkg::OP_JALR: begin
                    c.data  = pc + 32'd4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                rv32e_pkg::OP_BRANCH: begin
                    c.gpr_we = 1'b0;
                    case (f3)
                        3'h0:    cond = (a == b);
                        3'h1:    cond = (a != b);
                        3'h4:    cond = ($signed(a) < $signed(b));
                        3'h5:    cond = ($signed(a) >= $signed(b));
                        3'h6:    cond = (a < b);
                        default: cond = (a >= b);
                    endcase
                    if (cond) begin
                        next_pc = pc + imm_b;
                    end
                end
                default: begin
                    c.gpr_we    = 1'b0;
                    stop        = 1'b1;
                    exp_illegal = (inst != EBREAK);
                end
            endcase
            if (c.gpr_we && c.rd != 4'd0) begin
                regs[c.rd] = c.data;
            end
            exp_q.push_back(c);
            gap_q.push_back(gap);
            gap = (next_pc != pc + 32'd4) ? 3 : 1; // Two bubbles after a redirect
            pc  = next_pc;
        end
    endtask

    task automatic run_program();
        int n;
        int gap;
        int cycles;
        model_run();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_bit("commit_valid in reset", commit_valid, 1'b0);
            check_bit("halted in reset", halted, 1'b0);
            check_bit("illegal in reset", illegal, 1'b0);
            check_word("imem_addr in reset", imem_addr, rv32e_pkg::RESET_PC);
        end
        rst    = 1'b0;
        n      = 0;
        gap    = 0;
        cycles = 0;
        while (n < exp_q.size() && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            gap++;
            if (commit_valid) begin
                check_word("commit.pc", commit.pc, exp_q[n].pc);
                check_bit("commit.gpr_we", commit.gpr_we, exp_q[n].gpr_we);
                if (exp_q[n].gpr_we) begin
                    check_idx("commit.rd", commit.rd, exp_q[n].rd);
                    check_word("commit.data", commit.data, exp_q[n].data);
                end
                if (n > 0) begin
                    check_word("commit gap", rv32e_pkg::xlen_t'(gap),
                               rv32e_pkg::xlen_t'(gap_q[n]));
                end
                gap = 0;
                n++;
            end
        end
        if (n < exp_q.size()) begin
            errors++;
            $display("Core retired only %0d of %0d expected instructions", n, exp_q.size());
        end
        repeat (2) @(negedge clk);
        check_bit("halted", halted, 1'b1);
        check_bit("illegal", illegal, exp_illegal);
        repeat (20) begin
            @(negedge clk);
            if (commit_valid) begin
                errors++;
                $display("Unexpected commit at pc %h after the core halted", commit.pc);
            end
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        clear_program();
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            $display("test %s finished with no errors", name);
        end else begin
            tests_failed++;
            $display("test %s finished with %0d errors", name, errors - test_start_errors);
        end
    endtask

    `include "rv32e_core_tests.svh"

    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed         = 71;
        errors       = 0;
        tests_failed = 0;
        rst          = 1'b1;
        clear_program();
        test_alu();
        test_chain();
        test_branches();
        test_jumps();
        test_halt();
        test_illegal();
        $display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rv32e_core.f ====
+incdir+dv
verilog/rv32e_pkg.sv
verilog/rv32e_fetch.sv
verilog/rv32e_gpr.sv
verilog/rv32e_decode.sv
verilog/rv32e_execute.sv
verilog/rv32e_core.sv
dv/rv32e_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv32e_core_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= rv32e_core.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, LOG, BUILD_DIR, FILELIST"

test:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
